// File: include/uart_macros.svh
`ifndef UART_MACROS_SVH
`define UART_MACROS_SVH

// Host command word and line byte widths
`define UART_CMD_WIDTH  16
`define UART_DATA_WIDTH 8

// The clocks per bit on tx and rx must be 2 or more
`define UART_BAUD_DIV   8

// Idle line clocks after every stop bit
`define UART_GAP_CYCLES 16

// The byte FIFO depth is a power of two
`define UART_FIFO_DEPTH 4

`endif

// File: hdl/uart_cmd_pkg.sv
package uart_cmd_pkg;

  // Command bit 15 selects the operation
  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } cmd_op_e;

  typedef enum logic [1:0] {
    SEQ_IDLE,
    SEQ_PUSH_HI,
    SEQ_PUSH_LO,
    SEQ_WAIT_REPLY
  } seq_state_e;

  typedef enum logic [2:0] {
    TX_IDLE,
    TX_START,
    TX_DATA,
    TX_PARITY,
    TX_STOP,
    TX_GAP
  } tx_state_e;

  typedef enum logic [2:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_PARITY,
    RX_STOP
  } rx_state_e;

endpackage

// File: hdl/cmd_byte_fifo.sv
`timescale 1ns/1ns
`include "uart_macros.svh"

module cmd_byte_fifo (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        push,
  input  logic [`UART_DATA_WIDTH-1:0] push_data,
  input  logic                        pop,
  output logic [`UART_DATA_WIDTH-1:0] pop_data,
  output logic                        not_empty,
  output logic                        free_two
);

  localparam int AW = $clog2(`UART_FIFO_DEPTH);
  localparam logic [AW:0] FREE_TWO_MAX = (AW + 1)'(`UART_FIFO_DEPTH - 2);

  logic [`UART_DATA_WIDTH-1:0] mem [`UART_FIFO_DEPTH];
  logic [AW-1:0]               wr_ptr;
  logic [AW-1:0]               rd_ptr;
  logic [AW:0]                 count;

  always_ff @(posedge clk)
  begin
    if (push)
      mem[wr_ptr] <= push_data;
  end

  // Pointers wrap by themselves since the depth is a power of two
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr <= wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  assign pop_data  = mem[rd_ptr];
  assign not_empty = (count != '0);
  assign free_two  = (count <= FREE_TWO_MAX);

endmodule

// File: hdl/uart_cmd_sequencer.sv
`timescale 1ns/1ns
`include "uart_macros.svh"

module uart_cmd_sequencer
  import uart_cmd_pkg::*;
(
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic [`UART_CMD_WIDTH-1:0]  cmd_in,
  input  logic                        cmd_vld,
  output logic                        cmd_rdy,
  input  logic                        free_two,
  output logic                        push,
  output logic [`UART_DATA_WIDTH-1:0] push_data,
  input  logic [`UART_DATA_WIDTH-1:0] rx_byte,
  input  logic                        rx_bad,
  input  logic                        rx_done,
  output logic [`UART_DATA_WIDTH-1:0] read_data,
  output logic                        read_rdy,
  output logic                        parity_err
);

  seq_state_e                 state;
  seq_state_e                 state_nxt;
  logic [`UART_CMD_WIDTH-1:0] cmd_buf;
  cmd_op_e                    cmd_op;
  logic                       cmd_take;
  logic                       reply_take;

  // Only accept a command when both of its bytes are sure to fit
  assign cmd_rdy    = (state == SEQ_IDLE) && free_two;
  assign cmd_take   = cmd_vld && cmd_rdy;
  assign cmd_op     = cmd_op_e'(cmd_buf[`UART_CMD_WIDTH-1]);
  assign reply_take = (state == SEQ_WAIT_REPLY) && rx_done;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Command FSM
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb
  begin
    state_nxt = state;
    case (state)
      SEQ_IDLE:
        if (cmd_take)
          state_nxt = SEQ_PUSH_HI;
      SEQ_PUSH_HI:
        if (cmd_op == OP_WRITE)
          state_nxt = SEQ_PUSH_LO;
        else
          state_nxt = SEQ_WAIT_REPLY;
      SEQ_PUSH_LO:
        state_nxt = SEQ_IDLE;
      SEQ_WAIT_REPLY:
        if (rx_done)
          state_nxt = SEQ_IDLE;
      default:
        state_nxt = SEQ_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= SEQ_IDLE;
      read_rdy <= 1'b0;
    end
    else
    begin
      state    <= state_nxt;
      read_rdy <= reply_take;
    end
  end

  always_ff @(posedge clk)
  begin
    if (cmd_take)
      cmd_buf <= cmd_in;
    if (reply_take)
    begin
      read_data  <= rx_byte;
      parity_err <= rx_bad;
    end
  end

  // The high byte goes first and the low byte follows only for writes
  assign push      = (state == SEQ_PUSH_HI) || (state == SEQ_PUSH_LO);
  assign push_data = (state == SEQ_PUSH_LO) ?
                     cmd_buf[`UART_DATA_WIDTH-1:0] :
                     cmd_buf[`UART_CMD_WIDTH-1 -: `UART_DATA_WIDTH];

endmodule

// File: hdl/uart_frame_tx.sv
`timescale 1ns/1ns
`include "uart_macros.svh"

module uart_frame_tx
  import uart_cmd_pkg::*;
(
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        not_empty,
  output logic                        pop,
  input  logic [`UART_DATA_WIDTH-1:0] pop_data,
  output logic                        tx
);

  localparam int CNT_W = $clog2(`UART_BAUD_DIV + `UART_GAP_CYCLES);
  localparam int BIT_W = $clog2(`UART_DATA_WIDTH);
  localparam logic [CNT_W-1:0] BIT_LAST  = CNT_W'(`UART_BAUD_DIV - 1);
  localparam logic [CNT_W-1:0] GAP_LAST  = CNT_W'(`UART_GAP_CYCLES - 1);
  localparam logic [BIT_W-1:0] DATA_LAST = BIT_W'(`UART_DATA_WIDTH - 1);

  tx_state_e                   state;
  logic [CNT_W-1:0]            cnt;
  logic [BIT_W-1:0]            bit_idx;
  logic [`UART_DATA_WIDTH-1:0] tx_byte;
  logic                        cnt_end;

  assign pop     = (state == TX_IDLE) && not_empty;
  // The same counter times every bit and the idle gap
  assign cnt_end = (state == TX_GAP) ? (cnt == GAP_LAST) : (cnt == BIT_LAST);

  always_ff @(posedge clk)
  begin
    if (pop)
      tx_byte <= pop_data;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Frame FSM
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state   <= TX_IDLE;
      cnt     <= '0;
      bit_idx <= '0;
    end
    else if (state == TX_IDLE)
    begin
      cnt     <= '0;
      bit_idx <= '0;
      if (not_empty)
        state <= TX_START;
    end
    else if (!cnt_end)
      cnt <= cnt + 1'b1;
    else
    begin
      cnt <= '0;
      case (state)
        TX_START:
          state <= TX_DATA;
        TX_DATA:
        begin
          bit_idx <= bit_idx + 1'b1;
          if (bit_idx == DATA_LAST)
            state <= TX_PARITY;
        end
        TX_PARITY:
          state <= TX_STOP;
        TX_STOP:
          state <= TX_GAP;
        default:
          state <= TX_IDLE;
      endcase
    end
  end

  // The parity bit gives the nine bits an odd count of ones
  always_comb
  begin
    case (state)
      TX_START:  tx = 1'b0;
      TX_DATA:   tx = tx_byte[bit_idx];
      TX_PARITY: tx = ~^tx_byte;
      default:   tx = 1'b1;
    endcase
  end

endmodule

// File: hdl/uart_frame_rx.sv
`timescale 1ns/1ns
`include "uart_macros.svh"

module uart_frame_rx
  import uart_cmd_pkg::*;
(
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        rx,
  output logic [`UART_DATA_WIDTH-1:0] rx_byte,
  output logic                        rx_bad,
  output logic                        rx_done
);

  localparam int CNT_W = $clog2(`UART_BAUD_DIV);
  localparam int BIT_W = $clog2(`UART_DATA_WIDTH);
  localparam logic [CNT_W-1:0] BIT_LAST  = CNT_W'(`UART_BAUD_DIV - 1);
  localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(`UART_BAUD_DIV / 2 - 1);
  localparam logic [BIT_W-1:0] DATA_LAST = BIT_W'(`UART_DATA_WIDTH - 1);

  rx_state_e                   state;
  logic                        rx_meta;
  logic                        rx_sync;
  logic                        rx_sync_d;
  logic [CNT_W-1:0]            cnt;
  logic [BIT_W-1:0]            bit_idx;
  logic [`UART_DATA_WIDTH-1:0] shreg;
  logic                        par_bit;
  logic                        start_edge;
  logic                        sample;

  assign start_edge = rx_sync_d && !rx_sync;
  // The start bit is sampled after half a bit and every later bit one full bit on
  assign sample     = (state == RX_START) ? (cnt == HALF_LAST) : (cnt == BIT_LAST);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_meta   <= 1'b1;
      rx_sync   <= 1'b1;
      rx_sync_d <= 1'b1;
      state     <= RX_IDLE;
      cnt       <= '0;
      bit_idx   <= '0;
    end
    else
    begin
      rx_meta   <= rx;
      rx_sync   <= rx_meta;
      rx_sync_d <= rx_sync;
      if (state == RX_IDLE)
      begin
        cnt     <= '0;
        bit_idx <= '0;
        if (start_edge)
          state <= RX_START;
      end
      else if (!sample)
        cnt <= cnt + 1'b1;
      else
      begin
        cnt <= '0;
        case (state)
          // A glitch shorter than half a bit drops back to idle
          RX_START:
            state <= rx_sync ? RX_IDLE : RX_DATA;
          RX_DATA:
          begin
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == DATA_LAST)
              state <= RX_PARITY;
          end
          RX_PARITY:
            state <= RX_STOP;
          default:
            state <= RX_IDLE;
        endcase
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (sample && (state == RX_DATA))
      shreg <= {rx_sync, shreg[`UART_DATA_WIDTH-1:1]};
    if (sample && (state == RX_PARITY))
      par_bit <= rx_sync;
  end

  assign rx_done = sample && (state == RX_STOP);
  assign rx_byte = shreg;
  assign rx_bad  = !(^{par_bit, shreg}) || !rx_sync;

endmodule

// File: hdl/uart_cmd_master.sv
`timescale 1ns/1ns
`include "uart_macros.svh"

module uart_cmd_master (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic [`UART_CMD_WIDTH-1:0]  cmd_in,
  input  logic                        cmd_vld,
  input  logic                        rx,
  output logic                        tx,
  output logic                        cmd_rdy,
  output logic [`UART_DATA_WIDTH-1:0] read_data,
  output logic                        read_rdy,
  output logic                        parity_err
);

  logic                        push;
  logic [`UART_DATA_WIDTH-1:0] push_data;
  logic                        pop;
  logic [`UART_DATA_WIDTH-1:0] pop_data;
  logic                        not_empty;
  logic                        free_two;
  logic [`UART_DATA_WIDTH-1:0] rx_byte;
  logic                        rx_bad;
  logic                        rx_done;

  uart_cmd_sequencer u_seq (
    .clk        (clk),
    .rst_n      (rst_n),
    .cmd_in     (cmd_in),
    .cmd_vld    (cmd_vld),
    .cmd_rdy    (cmd_rdy),
    .free_two   (free_two),
    .push       (push),
    .push_data  (push_data),
    .rx_byte    (rx_byte),
    .rx_bad     (rx_bad),
    .rx_done    (rx_done),
    .read_data  (read_data),
    .read_rdy   (read_rdy),
    .parity_err (parity_err)
  );

  // Bytes wait here while earlier frames are still on the line
  cmd_byte_fifo u_fifo (
    .clk       (clk),
    .rst_n     (rst_n),
    .push      (push),
    .push_data (push_data),
    .pop       (pop),
    .pop_data  (pop_data),
    .not_empty (not_empty),
    .free_two  (free_two)
  );

  uart_frame_tx u_tx (
    .clk       (clk),
    .rst_n     (rst_n),
    .not_empty (not_empty),
    .pop       (pop),
    .pop_data  (pop_data),
    .tx        (tx)
  );

  uart_frame_rx u_rx (
    .clk     (clk),
    .rst_n   (rst_n),
    .rx      (rx),
    .rx_byte (rx_byte),
    .rx_bad  (rx_bad),
    .rx_done (rx_done)
  );

endmodule

// File: test/tb_clock.sv
`timescale 1ns/1ns

module tb_clock (
  output logic clk,
  output logic rst_n
);

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Reset is released a little after the second rising edge
  initial
  begin
    rst_n = 1'b0;
    repeat (2) @(posedge clk);
    #10;
    rst_n = 1'b1;
  end

endmodule

// File: test/uart_cmd_master_assertions.sv
`timescale 1ns/1ns
`include "uart_macros.svh"

module uart_cmd_master_assertions (
  input logic                       clk,
  input logic                       rst_n,
  input logic                       tx,
  input logic [`UART_CMD_WIDTH-1:0] cmd_in,
  input logic                       cmd_vld,
  input logic                       cmd_rdy,
  input logic                       read_rdy
);

  // The line idles high while the design is held in reset
  tx_high_in_reset: assert property (@(posedge clk) !rst_n |-> tx)
    else $error("tx is low while reset is asserted");

  read_rdy_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    read_rdy |=> !read_rdy)
    else $error("read_rdy stayed high for more than one cycle");

  // A waiting host must not change the command under cmd_vld
  cmd_in_stable: assert property (@(posedge clk) disable iff (!rst_n)
    cmd_vld && !cmd_rdy |=> $stable(cmd_in))
    else $error("cmd_in changed while cmd_vld waited on cmd_rdy");

endmodule

bind uart_cmd_master uart_cmd_master_assertions u_assertions (
  .clk      (clk),
  .rst_n    (rst_n),
  .tx       (tx),
  .cmd_in   (cmd_in),
  .cmd_vld  (cmd_vld),
  .cmd_rdy  (cmd_rdy),
  .read_rdy (read_rdy)
);

// File: test/tb_uart_cmd_master.sv
`timescale 1ns/1ns
`include "uart_macros.svh"

module tb_uart_cmd_master
  import uart_cmd_pkg::*;
();

  localparam int BAUD = `UART_BAUD_DIV;
  localparam int GAP  = `UART_GAP_CYCLES;
  localparam int DW   = `UART_DATA_WIDTH;
  // High clocks left in the stop bit after its mid-bit sample
  localparam int STOP_TAIL  = BAUD - 1 - BAUD / 2;
  localparam int CMD_BUDGET = 3 * 11 * BAUD + 2 * GAP + 40;

  logic                       clk;
  logic                       rst_n;
  logic [`UART_CMD_WIDTH-1:0] cmd_in;
  logic                       cmd_vld;
  logic                       rx;
  logic                       tx;
  logic                       cmd_rdy;
  logic [DW-1:0]              read_data;
  logic                       read_rdy;
  logic                       parity_err;

  cmd_op_e                    gold_op[$];
  logic [`UART_CMD_WIDTH-1:0] gold_cmd[$];
  logic [DW-1:0]              gold_reply[$];
  logic                       gold_bad[$];
  logic [DW-1:0]              gold_exp[$];

  // Bytes expected on tx carry the golden line of their read as a tag or -1 for writes
  logic [DW-1:0] exp_q[$];
  int            exp_tag[$];
  int            reply_q[$];
  int            pending_read[$];
  int            n_cmds = 0;
  int            n_reads = 0;
  int            reads_done = 0;
  logic          saw_stall = 1'b0;

  tb_clock u_clock (
    .clk   (clk),
    .rst_n (rst_n)
  );

  uart_cmd_master u_uart_cmd_master (
    .clk        (clk),
    .rst_n      (rst_n),
    .cmd_in     (cmd_in),
    .cmd_vld    (cmd_vld),
    .rx         (rx),
    .tx         (tx),
    .cmd_rdy    (cmd_rdy),
    .read_data  (read_data),
    .read_rdy   (read_rdy),
    .parity_err (parity_err)
  );

  task automatic stop_run();
    $display("Test failures found");
    $fatal(1, "stopping at the first failed check");
  endtask

  task automatic check_value(input string name, input logic [15:0] got,
                             input logic [15:0] expected);
    assert (got === expected)
    else
    begin
      $display("error: time %0t: %s is %h, expected %h", $time, name, got, expected);
      stop_run();
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    assert (cond === 1'b1)
    else
    begin
      $display("error: time %0t: %s", $time, what);
      stop_run();
    end
  endtask

  task automatic load_golden();
    int            fd;
    int            fields;
    string         line;
    logic          op;
    logic [15:0]   cmd;
    logic [DW-1:0] reply;
    logic          bad;
    logic [DW-1:0] expected;
    fd = $fopen("test/uart_golden.txt", "r");
    check_true(fd != 0, "could not open test/uart_golden.txt");
    while ($fgets(line, fd) > 0)
    begin
      if (line.len() == 0 || line[0] == "#")
        continue;
      fields = $sscanf(line, "%h %h %h %h %h", op, cmd, reply, bad, expected);
      if (fields <= 0)
        continue;
      check_true(fields == 5, "golden line does not hold five fields");
      check_true(op == cmd[15], "golden opcode does not match command bit 15");
      gold_op.push_back(cmd_op_e'(op));
      gold_cmd.push_back(cmd);
      gold_reply.push_back(reply);
      gold_bad.push_back(bad);
      gold_exp.push_back(expected);
      if (cmd_op_e'(op) == OP_READ)
        n_reads++;
    end
    $fclose(fd);
    n_cmds = gold_cmd.size();
    check_true(n_cmds > 0, "golden file holds no commands");
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Line model
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Called on the first falling clock edge of a start bit
  task automatic read_tx_frame(output logic [DW-1:0] data);
    logic parity;
    repeat (BAUD / 2) @(negedge clk);
    check_value("tx start bit", 16'(tx), 16'h0000);
    for (int b = 0; b < DW; b++)
    begin
      repeat (BAUD) @(negedge clk);
      data[b] = tx;
    end
    repeat (BAUD) @(negedge clk);
    parity = tx;
    check_value("tx parity bit", 16'(parity), 16'(~^data));
    repeat (BAUD) @(negedge clk);
    check_value("tx stop bit", 16'(tx), 16'h0001);
  endtask

  task automatic drive_rx_bit(input logic value);
    rx = value;
    repeat (BAUD) @(posedge clk);
    #10;
  endtask

  task automatic send_rx_byte(input logic [DW-1:0] value, input logic corrupt);
    logic parity;
    parity = ~^value;
    if (corrupt)
      parity = ~parity;
    drive_rx_bit(1'b0);
    for (int b = 0; b < DW; b++)
      drive_rx_bit(value[b]);
    drive_rx_bit(parity);
    drive_rx_bit(1'b1);
  endtask

  initial
  begin : tx_decoder
    int            high_run;
    logic          seen_frame;
    logic [DW-1:0] data;
    logic [DW-1:0] expected;
    int            tag;
    high_run   = 0;
    seen_frame = 1'b0;
    wait (rst_n === 1'b1);
    forever
    begin
      @(negedge clk);
      if (tx === 1'b1)
        high_run++;
      else
      begin
        if (seen_frame)
          check_true(high_run - STOP_TAIL >= GAP, "tx frame started inside the idle gap");
        check_true(exp_q.size() > 0, "a frame appeared on tx with no byte pending");
        expected = exp_q.pop_front();
        tag      = exp_tag.pop_front();
        read_tx_frame(data);
        check_value("tx byte", 16'(data), 16'(expected));
        if (tag >= 0)
          reply_q.push_back(tag);
        high_run   = 0;
        seen_frame = 1'b1;
      end
    end
  end

  initial
  begin : rx_replier
    int idx;
    rx = 1'b1;
    wait (rst_n === 1'b1);
    forever
    begin
      @(posedge clk);
      if (reply_q.size() > 0)
      begin
        idx = reply_q.pop_front();
        #10;
        send_rx_byte(gold_reply[idx], gold_bad[idx]);
      end
    end
  end

  initial
  begin : read_monitor
    int idx;
    wait (rst_n === 1'b1);
    forever
    begin
      @(negedge clk);
      if (read_rdy !== 1'b0)
      begin
        check_true(pending_read.size() > 0, "read_rdy pulsed with no read pending");
        idx = pending_read.pop_front();
        check_value("read_data", 16'(read_data), 16'(gold_exp[idx]));
        check_value("parity_err", 16'(parity_err), 16'(gold_bad[idx]));
        reads_done++;
      end
    end
  end

  initial
  begin : watchdog
    wait (n_cmds > 0);
    repeat (n_cmds * CMD_BUDGET) @(posedge clk);
    $display("error: time %0t: the run did not finish in %0d clock cycles",
             $time, n_cmds * CMD_BUDGET);
    stop_run();
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Host
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  initial
  begin : host_driver
    int   idle;
    int   stall_cycles;
    logic accepted;
    logic is_write;
    logic prev_write;
    cmd_in  = '0;
    cmd_vld = 1'b0;
    void'($urandom(75));
    load_golden();
    wait (rst_n === 1'b1);
    @(posedge clk);
    #10;
    prev_write = 1'b0;
    for (int i = 0; i < n_cmds; i++)
    begin
      is_write = (gold_op[i] == OP_WRITE);
      // Writes after a write go back to back so the FIFO fills up
      if (is_write && prev_write)
        idle = 0;
      else
        idle = int'($urandom % 21);
      if (i == 0)
        idle = idle + 3;
      repeat (idle)
      begin
        if (i == 0)
        begin
          check_value("tx", 16'(tx), 16'h0001);
          check_value("cmd_rdy", 16'(cmd_rdy), 16'h0001);
        end
        @(posedge clk);
        #10;
      end
      cmd_in       = gold_cmd[i];
      cmd_vld      = 1'b1;
      accepted     = 1'b0;
      stall_cycles = 0;
      while (!accepted)
      begin
        @(negedge clk);
        accepted = cmd_rdy;
        if (!accepted)
          stall_cycles++;
        @(posedge clk);
        #10;
      end
      cmd_vld = 1'b0;
      // The two push cycles alone keep cmd_rdy low for two clocks
      if (is_write && prev_write && stall_cycles > 2)
        saw_stall = 1'b1;
      exp_q.push_back(gold_cmd[i][15:8]);
      exp_tag.push_back(is_write ? -1 : i);
      if (is_write)
      begin
        exp_q.push_back(gold_cmd[i][7:0]);
        exp_tag.push_back(-1);
      end
      else
        pending_read.push_back(i);
      prev_write = is_write;
    end
    while (exp_q.size() != 0 || pending_read.size() != 0 || reads_done != n_reads)
      @(negedge clk);
    // One more frame time lets a stray byte on tx still be caught
    repeat (11 * BAUD + GAP) @(negedge clk);
    check_true(saw_stall, "back-to-back writes never found the FIFO full");
    $display("All tests passed!");
    $finish;
  end

endmodule

// File: files.f
+incdir+include
hdl/uart_cmd_pkg.sv
hdl/cmd_byte_fifo.sv
hdl/uart_cmd_sequencer.sv
hdl/uart_frame_tx.sv
hdl/uart_frame_rx.sv
hdl/uart_cmd_master.sv
test/tb_clock.sv
test/uart_cmd_master_assertions.sv
test/tb_uart_cmd_master.sv

// File: Makefile
TOP := tb_uart_cmd_master

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f files.f
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// File: test/uart_golden.txt
# op cmd reply corrupt expected_read_data, all in hex
# op 1 is a write; a read's reply goes out with its parity inverted when corrupt is 1
1 A53C 00 0 00
1 C0FF 00 0 00
1 FE01 00 0 00
1 8E71 00 0 00
0 125A 3C 0 3C
0 7F00 A7 1 A7
1 9B46 00 0 00
1 F0F0 00 0 00
0 0081 00 0 00
0 6DE2 FF 1 FF
